/* hw/video_timing_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Capture side and readout schedule geometry
////////////////////////////////////////////////////////////////////////////

package video_timing_pkg;

    // Horizontal and vertical counter type
    typedef logic [10:0] count_t;

    // Pixel clocks per line
    localparam count_t h_total = 11'd100;
    // Lines per frame
    localparam count_t v_total = 11'd14;

    // Capture window start on each active line
    localparam count_t first_pix = 11'd8;

    // Active line range, inclusive
    localparam count_t v_first = 11'd3;
    localparam count_t v_last = 11'd10;

    // Test mode switches from line index to address pattern here
    localparam count_t v_test_split = 11'd7;

    // Readout of the buffered line begins here, clear of the write window
    localparam count_t read_start = 11'd30;

endpackage

`default_nettype wire

/* hw/lvds_format_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Output word and lane format
////////////////////////////////////////////////////////////////////////////

package lvds_format_pkg;

    // Words per line, also buffer depth
    localparam int line_words = 16;
    // Lanes per captured word
    localparam int lanes = 5;
    localparam int lane_bits = 16;
    localparam int word_bits = lanes * lane_bits;
    // Buffer address width
    localparam int addr_bits = 4;

    typedef logic [lane_bits-1:0] lane_t;
    typedef logic [word_bits-1:0] word_t;
    typedef logic [addr_bits-1:0] addr_t;

endpackage

`default_nettype wire

/* hw/line_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module line_capture
    import video_timing_pkg::*;
    import lvds_format_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire count_t pix_h,
    input  wire count_t pix_v,
    input  wire word_t  pix_data,
    input  wire logic   test_mode,
    output logic        wr_en,
    output addr_t       wr_addr,
    output word_t       wr_word,
    output logic        frame_capture
);

    logic   active_row;
    logic   win_start;
    logic   win_last;
    addr_t  next_addr;
    count_t line_cnt;
    lane_t  addr_lane;
    word_t  test_word;

    // Row inside the active range
    assign active_row = (pix_v >= v_first) && (pix_v <= v_last);
    assign win_start = (pix_h == first_pix) && active_row;
    // Last word of the write window
    assign win_last = wr_en && (wr_addr == addr_t'(line_words - 1));

    // Address of the word registered at this edge
    assign next_addr = (wr_en && !win_last) ? wr_addr + addr_t'(1) : '0;

    // Test patterns
    assign addr_lane = lane_t'(next_addr);
    assign test_word = (pix_v < v_test_split) ? {(word_bits / 8){line_cnt[7:0]}}
                                              : {lanes{addr_lane}};

    ////////////////////////////////////////////////////////////////////////////
    // Write window and address
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_en <= 1'b0;
            wr_addr <= '0;
        end
        else
        begin
            // Open at first_pix, close after line_words writes
            if (win_start)
                wr_en <= 1'b1;
            else if (win_last)
                wr_en <= 1'b0;
            wr_addr <= next_addr;
        end
    end

    // Write word travels with wr_en and wr_addr
    always_ff @(posedge clk)
    begin
        wr_word <= test_mode ? test_word : pix_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Captured line index and frame level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_cnt <= '0;
            frame_capture <= 1'b0;
        end
        else
        begin
            // Counts finished lines, zero between frames
            if (!active_row)
                line_cnt <= '0;
            else if (win_last)
                line_cnt <= line_cnt + count_t'(1);

            // Up with first write of v_first, down after last write of v_last
            if (win_start && (pix_v == v_first))
                frame_capture <= 1'b1;
            else if (win_last && (pix_v == v_last))
                frame_capture <= 1'b0;
        end
    end

    // Each window starts writing at address zero
    a_addr_at_rise: assert property (
        @(posedge clk) disable iff (reset)
        $rose(wr_en) |-> (wr_addr == '0)
    );

endmodule

`default_nettype wire

/* hw/lane_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_ram
    import lvds_format_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  wr_en,
    input  wire addr_t wr_addr,
    input  wire lane_t wr_data,
    input  wire logic  rd_en,
    input  wire addr_t rd_addr,
    output lane_t      rd_data
);

    // One line of one lane
    lane_t mem [line_words];

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, holds between strobes
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/lane_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_serializer
    import video_timing_pkg::*;
    import lvds_format_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire count_t pix_h,
    input  wire count_t pix_v,
    input  wire lane_t  lane0_data,
    input  wire lane_t  lane1_data,
    input  wire lane_t  lane2_data,
    input  wire lane_t  lane3_data,
    input  wire lane_t  lane4_data,
    output logic        rd_en,
    output addr_t       rd_addr,
    output lane_t       out_data,
    output logic        line_valid,
    output logic        frame_valid
);

    logic [$clog2(lanes)-1:0] lane_cnt;
    logic  active;
    logic  start;
    logic  word_end;
    logic  first_line;
    logic  last_line;
    lane_t lane_sel;

    // Readout trigger on output lines
    assign start = (pix_h == read_start)
                && (pix_v >= v_first + count_t'(1))
                && (pix_v <= v_last + count_t'(1));

    // Last lane of the word now on the mux
    assign word_end = active && (lane_cnt == ($clog2(lanes))'(lanes - 1));

    // First word at start and then one fetch per word end
    // rd_addr wraps to zero once the last word is fetched
    assign rd_en = start || (word_end && (rd_addr != '0));

    ////////////////////////////////////////////////////////////////////////////
    // Read schedule
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_addr <= '0;
            active <= 1'b0;
            lane_cnt <= '0;
            first_line <= 1'b0;
            last_line <= 1'b0;
        end
        else
        begin
            // Steps on every fetch and so on every lane wrap
            if (rd_en)
                rd_addr <= rd_addr + addr_t'(1);

            // rd_addr back at zero marks the last word on the mux
            if (start)
                active <= 1'b1;
            else if (word_end && (rd_addr == '0))
                active <= 1'b0;

            if (!active || word_end)
                lane_cnt <= '0;
            else
                lane_cnt <= lane_cnt + 1'b1;

            // Row position latched since readout runs past the line wrap
            if (start)
            begin
                first_line <= (pix_v == v_first + count_t'(1));
                last_line <= (pix_v == v_last + count_t'(1));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lane mux and output levels
    ////////////////////////////////////////////////////////////////////////////

    // Lane 0 first and lowest bits first
    always_comb
    begin
        case (lane_cnt)
            3'd0: lane_sel = lane0_data;
            3'd1: lane_sel = lane1_data;
            3'd2: lane_sel = lane2_data;
            3'd3: lane_sel = lane3_data;
            default: lane_sel = lane4_data;
        endcase
    end

    always_ff @(posedge clk)
    begin
        out_data <= lane_sel;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_valid <= 1'b0;
            frame_valid <= 1'b0;
        end
        else
        begin
            // One cycle behind the mux select
            line_valid <= active;

            // Rises with first beat of the first output line
            if (active && !line_valid && first_line)
                frame_valid <= 1'b1;
            // Drops with line_valid after the last output line
            else if (line_valid && !active && last_line)
                frame_valid <= 1'b0;
        end
    end

    a_line_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        line_valid |-> frame_valid
    );

    // Previous line fully out before the next readout begins
    a_start_idle: assert property (
        @(posedge clk) disable iff (reset)
        start |-> (!active && !line_valid)
    );

endmodule

`default_nettype wire

/* hw/line_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

module line_bridge_top
    import video_timing_pkg::*;
    import lvds_format_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire count_t pix_h,
    input  wire count_t pix_v,
    input  wire word_t  pix_data,
    input  wire logic   test_mode,
    output lane_t       out_data,
    output logic        line_valid,
    output logic        frame_valid,
    output logic        buf_write,
    output logic        frame_capture
);

    // Write side, buf_write doubles as the shared write enable
    addr_t wr_addr;
    word_t wr_word;

    // Read side
    logic  rd_en;
    addr_t rd_addr;
    lane_t rd_lane [lanes];

    line_capture i_capture (
        .clk           (clk),
        .reset         (reset),
        .pix_h         (pix_h),
        .pix_v         (pix_v),
        .pix_data      (pix_data),
        .test_mode     (test_mode),
        .wr_en         (buf_write),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .frame_capture (frame_capture)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One buffer per lane, lane k on bits 16k up
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < lanes; k++)
    begin : g_lane
        lane_ram i_ram (
            .clk     (clk),
            .wr_en   (buf_write),
            .wr_addr (wr_addr),
            .wr_data (wr_word[k*lane_bits +: lane_bits]),
            .rd_en   (rd_en),
            .rd_addr (rd_addr),
            .rd_data (rd_lane[k])
        );
    end

    lane_serializer i_serializer (
        .clk         (clk),
        .reset       (reset),
        .pix_h       (pix_h),
        .pix_v       (pix_v),
        .lane0_data  (rd_lane[0]),
        .lane1_data  (rd_lane[1]),
        .lane2_data  (rd_lane[2]),
        .lane3_data  (rd_lane[3]),
        .lane4_data  (rd_lane[4]),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .out_data    (out_data),
        .line_valid  (line_valid),
        .frame_valid (frame_valid)
    );

endmodule

`default_nettype wire

/* testbench/tb_line_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_line_bridge
    import video_timing_pkg::*;
    import lvds_format_pkg::*;
;

    localparam int frame_cycles = int'(v_total) * int'(h_total);
    localparam int active_lines = int'(v_last) - int'(v_first) + 1;
    localparam int max_frames = 4;
    localparam int wait_limit = 2 * int'(h_total);
    localparam word_t filler = {(word_bits / 8){8'ha5}};

    logic   clk;
    logic   reset;
    count_t pix_h;
    count_t pix_v;
    word_t  pix_data;
    logic   test_mode;
    lane_t  out_data;
    logic   line_valid;
    logic   frame_valid;
    logic   buf_write;
    logic   frame_capture;

    // Frame entries from the data file
    word_t file_words [max_frames][active_lines][line_words];
    logic  file_mode [max_frames];
    int    n_frames;

    // Line buffer model and predicted beats
    word_t model_buf [line_words];
    lane_t exp_beats [$];
    int    errors;

    line_bridge_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .pix_h         (pix_h),
        .pix_v         (pix_v),
        .pix_data      (pix_data),
        .test_mode     (test_mode),
        .out_data      (out_data),
        .line_valid    (line_valid),
        .frame_valid   (frame_valid),
        .buf_write     (buf_write),
        .frame_capture (frame_capture)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
    begin
        $display("SIMULATION FAILED");
        $fatal(1);
    end
    endtask

    task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    begin
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] time %0t %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
    begin
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] time %0t %s expected %b actual %b", $time, name, exp, act);
            stop_with_failure();
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Data file
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_frames();
        int    fd;
        int    r;
        int    flag;
        int    l_idx;
        string line;
    begin
        n_frames = 0;
        l_idx = -1;
        fd = $fopen("testbench/line_bridge_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
            stop_with_failure();
        end
        while (!$feof(fd) && (n_frames < max_frames))
        begin
            r = $fgets(line, fd);
            // Skip comments and blank lines
            if ((r == 0) || (line.len() < 2) || (line[0] == "#"))
                continue;
            if (l_idx < 0)
            begin
                r = $sscanf(line, "%d", flag);
                file_mode[n_frames] = (flag != 0);
                l_idx = 0;
            end
            else
            begin
                r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    file_words[n_frames][l_idx][0], file_words[n_frames][l_idx][1],
                    file_words[n_frames][l_idx][2], file_words[n_frames][l_idx][3],
                    file_words[n_frames][l_idx][4], file_words[n_frames][l_idx][5],
                    file_words[n_frames][l_idx][6], file_words[n_frames][l_idx][7],
                    file_words[n_frames][l_idx][8], file_words[n_frames][l_idx][9],
                    file_words[n_frames][l_idx][10], file_words[n_frames][l_idx][11],
                    file_words[n_frames][l_idx][12], file_words[n_frames][l_idx][13],
                    file_words[n_frames][l_idx][14], file_words[n_frames][l_idx][15]);
                if (r != line_words)
                begin
                    $display("Stimulus file line has a wrong number of pixel words");
                    stop_with_failure();
                end
                l_idx++;
                if (l_idx == active_lines)
                begin
                    n_frames++;
                    l_idx = -1;
                end
            end
        end
        $fclose(fd);
        if (n_frames < 3)
        begin
            $display("Stimulus file holds fewer than three frames");
            stop_with_failure();
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and prediction
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t pixel_word(input int idx, input int h, input int v);
    begin
        if ((v >= int'(v_first)) && (v <= int'(v_last))
            && (h >= int'(first_pix)) && (h < int'(first_pix) + line_words))
            return file_words[idx][v - int'(v_first)][h - int'(first_pix)];
        return filler;
    end
    endfunction

    // Upper rows carry the line index byte and lower rows the word address
    function automatic word_t pattern_word(input int v, input int a);
        logic [7:0] idx;
    begin
        idx = 8'(v - int'(v_first));
        if (v < int'(v_test_split))
            return {(word_bits / 8){idx}};
        return {lanes{lane_t'(a)}};
    end
    endfunction

    task automatic predict_cycle(input int idx, input int h, input int v);
        int a;
        int w;
        int k;
    begin
        // Word presented at first_pix+a lands at address a
        a = h - int'(first_pix);
        if ((v >= int'(v_first)) && (v <= int'(v_last)) && (a >= 0) && (a < line_words))
            model_buf[a] = file_mode[idx] ? pattern_word(v, a) : pixel_word(idx, h, v);

        // Readout snapshot of the buffer in word order then lane order
        if ((h == int'(read_start)) && (v >= int'(v_first) + 1) && (v <= int'(v_last) + 1))
        begin
            for (w = 0; w < line_words; w++)
                for (k = 0; k < lanes; k++)
                    exp_beats.push_back(model_buf[w][k*lane_bits +: lane_bits]);
        end
    end
    endtask

    task automatic check_cycle(input int t, input int h, input int v);
        logic exp_write;
        logic exp_capture;
        logic exp_line;
        logic exp_frame;
        int   beat_start;
    begin
        exp_write = (v >= int'(v_first)) && (v <= int'(v_last))
                 && (h > int'(first_pix)) && (h <= int'(first_pix) + line_words);
        exp_capture = ((v == int'(v_first)) && (h > int'(first_pix)))
                   || ((v > int'(v_first)) && (v < int'(v_last)))
                   || ((v == int'(v_last)) && (h <= int'(first_pix) + line_words));
        // 80 beats from read_start+2 that run past the line wrap
        beat_start = int'(read_start) + 2;
        exp_line = ((v >= int'(v_first) + 1) && (v <= int'(v_last) + 1) && (h >= beat_start))
                || ((v >= int'(v_first) + 2) && (v <= int'(v_last) + 2)
                    && (h < beat_start + lanes * line_words - int'(h_total)));
        exp_frame = (t >= (int'(v_first) + 1) * int'(h_total) + beat_start)
                 && (t < (int'(v_last) + 1) * int'(h_total) + beat_start
                         + lanes * line_words);

        check_level("buf_write", exp_write, buf_write);
        check_level("frame_capture", exp_capture, frame_capture);
        check_level("line_valid", exp_line, line_valid);
        check_level("frame_valid", exp_frame, frame_valid);
        if (exp_line)
        begin
            if (exp_beats.size() == 0)
            begin
                $display("Output beat at time %0t has no predicted value", $time);
                stop_with_failure();
            end
            check_lane("out_data", exp_beats.pop_front(), out_data);
        end
    end
    endtask

    // Levels must be low from the cycle after a mid-frame reset
    task automatic reset_mid_frame();
        int i;
    begin
        exp_beats.delete();
        for (i = 0; i < 5; i++)
        begin
            @(negedge clk);
            check_level("line_valid", 1'b0, line_valid);
            check_level("frame_valid", 1'b0, frame_valid);
            check_level("buf_write", 1'b0, buf_write);
            check_level("frame_capture", 1'b0, frame_capture);
            @(posedge clk);
        end
    end
    endtask

    // One whole frame or up to abort_at where reset is raised
    task automatic run_frame(input int idx, input int abort_at);
        int t;
        int h;
        int v;
    begin
        for (t = 0; t < frame_cycles; t++)
        begin
            h = t % int'(h_total);
            v = t / int'(h_total);
            if (t > 0)
                @(posedge clk);
            reset <= (t == abort_at);
            pix_h <= count_t'(h);
            pix_v <= count_t'(v);
            test_mode <= file_mode[idx];
            pix_data <= pixel_word(idx, h, v);
            predict_cycle(idx, h, v);
            @(negedge clk);
            check_cycle(t, h, v);
            if (t == abort_at)
            begin
                @(posedge clk);
                reset_mid_frame();
                return;
            end
        end
        @(posedge clk);
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Waits
    ////////////////////////////////////////////////////////////////////////////

    // DUT levels settle low before the first frame
    task automatic wait_idle_after_reset();
        int cycles;
    begin
        cycles = 0;
        @(negedge clk);
        while ((line_valid | frame_valid | buf_write | frame_capture) !== 1'b0)
        begin
            if (cycles >= wait_limit)
            begin
                $display("Timed out waiting for the DUT levels to go low after reset");
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    end
    endtask

    task automatic wait_frame_end();
        int cycles;
    begin
        cycles = 0;
        while ((exp_beats.size() != 0) || (frame_valid !== 1'b0))
        begin
            if (cycles >= wait_limit)
            begin
                $display("Timed out waiting for the end of the output frame");
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        pix_h = '0;
        pix_v = '0;
        pix_data = filler;
        test_mode = 1'b0;
        errors = 0;
        load_frames();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait_idle_after_reset();
        @(posedge clk);

        // Normal frame and test mode frame, then an aborted frame and the same frame in full
        run_frame(0, -1);
        run_frame(1, -1);
        run_frame(2, 6 * int'(h_total) + 50);
        run_frame(2, -1);
        wait_frame_end();

        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
            stop_with_failure();
    end

endmodule

`default_nettype wire

/* testbench/line_bridge_input.txt */
# Frame entry: test_mode flag line, then 8 active lines of 16 hex pixel words
# Each 80-bit word is lane4 down to lane0, lane k reads frame line word k
0
10041003100210011000 10141013101210111010 10241023102210211020 10341033103210311030 10441043104210411040 10541053105210511050 10641063106210611060 10741073107210711070 10841083108210811080 10941093109210911090 10a410a310a210a110a0 10b410b310b210b110b0 10c410c310c210c110c0 10d410d310d210d110d0 10e410e310e210e110e0 10f410f310f210f110f0
11041103110211011100 11141113111211111110 11241123112211211120 11341133113211311130 11441143114211411140 11541153115211511150 11641163116211611160 11741173117211711170 11841183118211811180 11941193119211911190 11a411a311a211a111a0 11b411b311b211b111b0 11c411c311c211c111c0 11d411d311d211d111d0 11e411e311e211e111e0 11f411f311f211f111f0
12041203120212011200 12141213121212111210 12241223122212211220 12341233123212311230 12441243124212411240 12541253125212511250 12641263126212611260 12741273127212711270 12841283128212811280 12941293129212911290 12a412a312a212a112a0 12b412b312b212b112b0 12c412c312c212c112c0 12d412d312d212d112d0 12e412e312e212e112e0 12f412f312f212f112f0
13041303130213011300 13141313131213111310 13241323132213211320 13341333133213311330 13441343134213411340 13541353135213511350 13641363136213611360 13741373137213711370 13841383138213811380 13941393139213911390 13a413a313a213a113a0 13b413b313b213b113b0 13c413c313c213c113c0 13d413d313d213d113d0 13e413e313e213e113e0 13f413f313f213f113f0
14041403140214011400 14141413141214111410 14241423142214211420 14341433143214311430 14441443144214411440 14541453145214511450 14641463146214611460 14741473147214711470 14841483148214811480 14941493149214911490 14a414a314a214a114a0 14b414b314b214b114b0 14c414c314c214c114c0 14d414d314d214d114d0 14e414e314e214e114e0 14f414f314f214f114f0
15041503150215011500 15141513151215111510 15241523152215211520 15341533153215311530 15441543154215411540 15541553155215511550 15641563156215611560 15741573157215711570 15841583158215811580 15941593159215911590 15a415a315a215a115a0 15b415b315b215b115b0 15c415c315c215c115c0 15d415d315d215d115d0 15e415e315e215e115e0 15f415f315f215f115f0
16041603160216011600 16141613161216111610 16241623162216211620 16341633163216311630 16441643164216411640 16541653165216511650 16641663166216611660 16741673167216711670 16841683168216811680 16941693169216911690 16a416a316a216a116a0 16b416b316b216b116b0 16c416c316c216c116c0 16d416d316d216d116d0 16e416e316e216e116e0 16f416f316f216f116f0
17041703170217011700 17141713171217111710 17241723172217211720 17341733173217311730 17441743174217411740 17541753175217511750 17641763176217611760 17741773177217711770 17841783178217811780 17941793179217911790 17a417a317a217a117a0 17b417b317b217b117b0 17c417c317c217c117c0 17d417d317d217d117d0 17e417e317e217e117e0 17f417f317f217f117f0
1
20042003200220012000 20142013201220112010 20242023202220212020 20342033203220312030 20442043204220412040 20542053205220512050 20642063206220612060 20742073207220712070 20842083208220812080 20942093209220912090 20a420a320a220a120a0 20b420b320b220b120b0 20c420c320c220c120c0 20d420d320d220d120d0 20e420e320e220e120e0 20f420f320f220f120f0
21042103210221012100 21142113211221112110 21242123212221212120 21342133213221312130 21442143214221412140 21542153215221512150 21642163216221612160 21742173217221712170 21842183218221812180 21942193219221912190 21a421a321a221a121a0 21b421b321b221b121b0 21c421c321c221c121c0 21d421d321d221d121d0 21e421e321e221e121e0 21f421f321f221f121f0
22042203220222012200 22142213221222112210 22242223222222212220 22342233223222312230 22442243224222412240 22542253225222512250 22642263226222612260 22742273227222712270 22842283228222812280 22942293229222912290 22a422a322a222a122a0 22b422b322b222b122b0 22c422c322c222c122c0 22d422d322d222d122d0 22e422e322e222e122e0 22f422f322f222f122f0
23042303230223012300 23142313231223112310 23242323232223212320 23342333233223312330 23442343234223412340 23542353235223512350 23642363236223612360 23742373237223712370 23842383238223812380 23942393239223912390 23a423a323a223a123a0 23b423b323b223b123b0 23c423c323c223c123c0 23d423d323d223d123d0 23e423e323e223e123e0 23f423f323f223f123f0
24042403240224012400 24142413241224112410 24242423242224212420 24342433243224312430 24442443244224412440 24542453245224512450 24642463246224612460 24742473247224712470 24842483248224812480 24942493249224912490 24a424a324a224a124a0 24b424b324b224b124b0 24c424c324c224c124c0 24d424d324d224d124d0 24e424e324e224e124e0 24f424f324f224f124f0
25042503250225012500 25142513251225112510 25242523252225212520 25342533253225312530 25442543254225412540 25542553255225512550 25642563256225612560 25742573257225712570 25842583258225812580 25942593259225912590 25a425a325a225a125a0 25b425b325b225b125b0 25c425c325c225c125c0 25d425d325d225d125d0 25e425e325e225e125e0 25f425f325f225f125f0
26042603260226012600 26142613261226112610 26242623262226212620 26342633263226312630 26442643264226412640 26542653265226512650 26642663266226612660 26742673267226712670 26842683268226812680 26942693269226912690 26a426a326a226a126a0 26b426b326b226b126b0 26c426c326c226c126c0 26d426d326d226d126d0 26e426e326e226e126e0 26f426f326f226f126f0
27042703270227012700 27142713271227112710 27242723272227212720 27342733273227312730 27442743274227412740 27542753275227512750 27642763276227612760 27742773277227712770 27842783278227812780 27942793279227912790 27a427a327a227a127a0 27b427b327b227b127b0 27c427c327c227c127c0 27d427d327d227d127d0 27e427e327e227e127e0 27f427f327f227f127f0
0
30043003300230013000 30143013301230113010 30243023302230213020 30343033303230313030 30443043304230413040 30543053305230513050 30643063306230613060 30743073307230713070 30843083308230813080 30943093309230913090 30a430a330a230a130a0 30b430b330b230b130b0 30c430c330c230c130c0 30d430d330d230d130d0 30e430e330e230e130e0 30f430f330f230f130f0
31043103310231013100 31143113311231113110 31243123312231213120 31343133313231313130 31443143314231413140 31543153315231513150 31643163316231613160 31743173317231713170 31843183318231813180 31943193319231913190 31a431a331a231a131a0 31b431b331b231b131b0 31c431c331c231c131c0 31d431d331d231d131d0 31e431e331e231e131e0 31f431f331f231f131f0
32043203320232013200 32143213321232113210 32243223322232213220 32343233323232313230 32443243324232413240 32543253325232513250 32643263326232613260 32743273327232713270 32843283328232813280 32943293329232913290 32a432a332a232a132a0 32b432b332b232b132b0 32c432c332c232c132c0 32d432d332d232d132d0 32e432e332e232e132e0 32f432f332f232f132f0
33043303330233013300 33143313331233113310 33243323332233213320 33343333333233313330 33443343334233413340 33543353335233513350 33643363336233613360 33743373337233713370 33843383338233813380 33943393339233913390 33a433a333a233a133a0 33b433b333b233b133b0 33c433c333c233c133c0 33d433d333d233d133d0 33e433e333e233e133e0 33f433f333f233f133f0
34043403340234013400 34143413341234113410 34243423342234213420 34343433343234313430 34443443344234413440 34543453345234513450 34643463346234613460 34743473347234713470 34843483348234813480 34943493349234913490 34a434a334a234a134a0 34b434b334b234b134b0 34c434c334c234c134c0 34d434d334d234d134d0 34e434e334e234e134e0 34f434f334f234f134f0
35043503350235013500 35143513351235113510 35243523352235213520 35343533353235313530 35443543354235413540 35543553355235513550 35643563356235613560 35743573357235713570 35843583358235813580 35943593359235913590 35a435a335a235a135a0 35b435b335b235b135b0 35c435c335c235c135c0 35d435d335d235d135d0 35e435e335e235e135e0 35f435f335f235f135f0
36043603360236013600 36143613361236113610 36243623362236213620 36343633363236313630 36443643364236413640 36543653365236513650 36643663366236613660 36743673367236713670 36843683368236813680 36943693369236913690 36a436a336a236a136a0 36b436b336b236b136b0 36c436c336c236c136c0 36d436d336d236d136d0 36e436e336e236e136e0 36f436f336f236f136f0
37043703370237013700 37143713371237113710 37243723372237213720 37343733373237313730 37443743374237413740 37543753375237513750 37643763376237613760 37743773377237713770 37843783378237813780 37943793379237913790 37a437a337a237a137a0 37b437b337b237b137b0 37c437c337c237c137c0 37d437d337d237d137d0 37e437e337e237e137e0 37f437f337f237f137f0

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_line_bridge
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
hw/video_timing_pkg.sv
hw/lvds_format_pkg.sv
hw/line_capture.sv
hw/lane_ram.sv
hw/lane_serializer.sv
hw/line_bridge_top.sv
testbench/tb_line_bridge.sv
